/* ctrl_pkg.sv */
`default_nettype none

package ctrl_pkg;

  typedef logic [3:0] opcode_t;
  typedef logic [5:0] func_t;

  // opcode field
  localparam opcode_t op_bne   = 4'd0;
  localparam opcode_t op_beq   = 4'd1;
  localparam opcode_t op_bgz   = 4'd2;
  localparam opcode_t op_blz   = 4'd3;
  localparam opcode_t op_adi   = 4'd4;
  localparam opcode_t op_ori   = 4'd5;
  localparam opcode_t op_lhi   = 4'd6;
  localparam opcode_t op_lwd   = 4'd7;
  localparam opcode_t op_swd   = 4'd8;
  localparam opcode_t op_jmp   = 4'd9;
  localparam opcode_t op_jal   = 4'd10;
  localparam opcode_t op_rtype = 4'd15;

  // function codes under op_rtype
  localparam func_t fn_add = 6'd0;
  localparam func_t fn_sub = 6'd1;
  localparam func_t fn_and = 6'd2;
  localparam func_t fn_orr = 6'd3;
  localparam func_t fn_not = 6'd4;
  localparam func_t fn_tcp = 6'd5;
  localparam func_t fn_shl = 6'd6;
  localparam func_t fn_shr = 6'd7;
  localparam func_t fn_jpr = 6'd25;
  localparam func_t fn_jrl = 6'd26;
  localparam func_t fn_wwd = 6'd28; // local encoding
  localparam func_t fn_hlt = 6'd29; // local encoding

  typedef enum logic [2:0] {
    st_if  = 3'd0,
    st_ex1 = 3'd1,
    st_ex2 = 3'd2,
    st_mem = 3'd3,
    st_wb  = 3'd4
  } ctrl_state_t;

  typedef enum logic [3:0] {
    cls_alu_r   = 4'd0,
    cls_jpr     = 4'd1,
    cls_jrl     = 4'd2,
    cls_imm     = 4'd3,
    cls_lwd     = 4'd4,
    cls_swd     = 4'd5,
    cls_branch  = 4'd6,
    cls_jmp     = 4'd7,
    cls_jal     = 4'd8,
    cls_wwd     = 4'd9,
    cls_hlt     = 4'd10,
    cls_illegal = 4'd11
  } inst_class_t;

  typedef struct packed {
    logic mem_write;
    logic mem_read;
    logic reg_write;
    logic reg_dst;          // rt as destination
    logic pc_to_reg;        // link value to register file
    logic mem_to_reg;
    logic alu_src_a;
    logic alu_src_b;        // immediate operand
    logic pc_store;
    logic branch_dst_store;
    logic branch;
    logic jal;
    logic jalr;
    logic pvs_update;       // instruction retires
    logic alu_op;
    logic halt;
    logic wwd;
  } ctrl_sig_t;

endpackage

`default_nettype wire

/* inst_decoder.sv */
`default_nettype none

module inst_decoder (
  input  ctrl_pkg::opcode_t     opcode,
  input  ctrl_pkg::func_t       func_code,
  output ctrl_pkg::inst_class_t inst_class
);

  import ctrl_pkg::*;

  always_comb begin
    inst_class = cls_illegal;
    case (opcode)
      op_rtype: begin
        case (func_code)
          fn_add,
          fn_sub,
          fn_and,
          fn_orr,
          fn_not,
          fn_tcp,
          fn_shl,
          fn_shr:  inst_class = cls_alu_r;
          fn_jpr:  inst_class = cls_jpr;
          fn_jrl:  inst_class = cls_jrl;
          fn_wwd:  inst_class = cls_wwd;
          fn_hlt:  inst_class = cls_hlt;
          default: inst_class = cls_illegal; // unused function code
        endcase
      end
      op_bne,
      op_beq,
      op_bgz,
      op_blz: begin
        inst_class = cls_branch;
      end
      op_adi,
      op_ori,
      op_lhi: begin
        inst_class = cls_imm;
      end
      op_lwd:  inst_class = cls_lwd;
      op_swd:  inst_class = cls_swd;
      op_jmp:  inst_class = cls_jmp;
      op_jal:  inst_class = cls_jal;
      default: inst_class = cls_illegal;
    endcase
  end

endmodule

`default_nettype wire

/* state_sequencer.sv */
`default_nettype none

module state_sequencer (
  input  logic                  clk,
  input  logic                  rst_n,
  input  ctrl_pkg::inst_class_t inst_class,
  output ctrl_pkg::ctrl_state_t cur_state,
  output logic                  step_last
);

  import ctrl_pkg::*;

  ctrl_state_t nxt_state;

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      cur_state <= st_if;
    end else begin
      cur_state <= nxt_state;
    end
  end

  // off-path combinations fall back to IF without retiring
  always_comb begin
    nxt_state = st_if;
    step_last = 1'b0;
    case (cur_state)
      st_if: begin
        case (inst_class)
          cls_alu_r,
          cls_imm,
          cls_lwd,
          cls_swd,
          cls_branch,
          cls_jpr,
          cls_jmp:  nxt_state = st_ex1;
          cls_jrl,
          cls_jal:  nxt_state = st_wb; // link write straight away
          cls_wwd:  step_last = 1'b1;  // single cycle
          default:  nxt_state = st_if; // hlt and illegal hold
        endcase
      end
      st_ex1: begin
        case (inst_class)
          cls_alu_r,
          cls_imm:    nxt_state = st_wb;
          cls_lwd,
          cls_swd:    nxt_state = st_mem;
          cls_branch: nxt_state = st_ex2;
          cls_jpr,
          cls_jmp:    step_last = 1'b1;
          default:    nxt_state = st_if;
        endcase
      end
      st_ex2: begin
        step_last = (inst_class == cls_branch);
      end
      st_mem: begin
        if (inst_class == cls_lwd) begin
          nxt_state = st_wb;
        end else begin
          step_last = (inst_class == cls_swd);
        end
      end
      st_wb: begin
        step_last = (inst_class == cls_alu_r) || (inst_class == cls_imm) ||
                    (inst_class == cls_lwd) || (inst_class == cls_jrl) ||
                    (inst_class == cls_jal);
      end
      default: nxt_state = st_if;
    endcase
  end

endmodule

`default_nettype wire

/* ctrl_signal_gen.sv */
`default_nettype none

module ctrl_signal_gen (
  input  ctrl_pkg::inst_class_t inst_class,
  input  ctrl_pkg::ctrl_state_t cur_state,
  input  logic                  step_last,
  output ctrl_pkg::ctrl_sig_t   ctrl
);

  import ctrl_pkg::*;

  always_comb begin
    ctrl = '0;
    case (inst_class)
      cls_alu_r: begin
        case (cur_state)
          st_if:  ctrl.pc_store = 1'b1;
          st_ex1: begin
            ctrl.alu_src_a = 1'b1;
            ctrl.alu_op    = 1'b1;
          end
          st_wb: begin
            ctrl.reg_write = 1'b1;
            ctrl.alu_src_a = 1'b1;
            ctrl.alu_op    = 1'b1;
          end
          default: ;
        endcase
      end
      cls_jpr: begin
        ctrl.jalr = (cur_state == st_if) || (cur_state == st_ex1);
      end
      cls_jrl: begin
        case (cur_state)
          st_if: begin
            ctrl.pc_store = 1'b1; // save return address
            ctrl.jalr     = 1'b1;
          end
          st_wb: begin
            ctrl.reg_write = 1'b1;
            ctrl.pc_to_reg = 1'b1;
            ctrl.jalr      = 1'b1;
          end
          default: ;
        endcase
      end
      cls_imm,
      cls_lwd,
      cls_swd: begin
        case (cur_state)
          st_if:  ctrl.pc_store = 1'b1;
          st_ex1: begin
            ctrl.alu_src_a = 1'b1; // base plus immediate
            ctrl.alu_src_b = 1'b1;
            ctrl.alu_op    = 1'b1;
          end
          st_mem: begin
            ctrl.mem_read  = (inst_class == cls_lwd);
            ctrl.mem_write = (inst_class == cls_swd);
            ctrl.alu_src_a = 1'b1; // hold the address
            ctrl.alu_src_b = 1'b1;
            ctrl.alu_op    = 1'b1;
          end
          st_wb: begin
            ctrl.reg_write  = 1'b1;
            ctrl.reg_dst    = 1'b1;
            ctrl.mem_to_reg = (inst_class == cls_lwd);
            ctrl.alu_src_a  = (inst_class == cls_imm);
            ctrl.alu_src_b  = (inst_class == cls_imm);
            ctrl.alu_op     = 1'b1;
          end
          default: ;
        endcase
      end
      cls_branch: begin
        case (cur_state)
          st_if: begin
            ctrl.pc_store = 1'b1;
            ctrl.branch   = 1'b1;
          end
          st_ex1: begin
            ctrl.alu_src_a        = 1'b1; // target address
            ctrl.alu_src_b        = 1'b1;
            ctrl.branch_dst_store = 1'b1;
            ctrl.branch           = 1'b1;
          end
          st_ex2: begin
            ctrl.alu_src_a = 1'b1; // condition compare
            ctrl.branch    = 1'b1;
            ctrl.alu_op    = 1'b1;
          end
          default: ;
        endcase
      end
      cls_jmp: begin
        ctrl.jal    = (cur_state == st_if) || (cur_state == st_ex1);
        ctrl.alu_op = (cur_state == st_ex1);
      end
      cls_jal: begin
        ctrl.jal       = (cur_state == st_if) || (cur_state == st_wb);
        ctrl.reg_write = (cur_state == st_wb); // link register
        ctrl.pc_to_reg = (cur_state == st_wb);
      end
      cls_wwd: begin
        ctrl.pc_store = (cur_state == st_if);
        ctrl.wwd      = (cur_state == st_if);
      end
      cls_hlt: begin
        ctrl.halt = (cur_state == st_if);
      end
      default: ctrl = '0; // illegal decode
    endcase
    ctrl.pvs_update = step_last;
  end

endmodule

`default_nettype wire

/* control_unit.sv */
`default_nettype none

module control_unit (
  input  logic                clk,
  input  logic                rst_n,
  input  ctrl_pkg::opcode_t   opcode,
  input  ctrl_pkg::func_t     func_code,
  output ctrl_pkg::ctrl_sig_t ctrl
);

  import ctrl_pkg::*;

  inst_class_t inst_class;
  ctrl_state_t cur_state;
  logic        step_last;

  inst_decoder i_decoder (
    .opcode     (opcode),
    .func_code  (func_code),
    .inst_class (inst_class)
  );

  state_sequencer i_sequencer (
    .clk        (clk),
    .rst_n      (rst_n),
    .inst_class (inst_class),
    .cur_state  (cur_state),
    .step_last  (step_last)
  );

  ctrl_signal_gen i_signal_gen (
    .inst_class (inst_class),
    .cur_state  (cur_state),
    .step_last  (step_last),
    .ctrl       (ctrl)
  );

endmodule

`default_nettype wire

/* control_unit_assert.sv */
`default_nettype none

module control_unit_assert (
  input logic                clk,
  input logic                rst_n,
  input ctrl_pkg::ctrl_sig_t ctrl
);

  mem_excl: assert property (@(posedge clk) disable iff (!rst_n)
    !(ctrl.mem_read && ctrl.mem_write))
    else $error("mem_read and mem_write high together");

  halt_no_retire: assert property (@(posedge clk) disable iff (!rst_n)
    !(ctrl.halt && ctrl.pvs_update))
    else $error("halt raised together with pvs_update");

  // the cycle after retiring is IF of the next instruction
  retire_to_if: assert property (@(posedge clk) disable iff (!rst_n)
    ctrl.pvs_update |=> (ctrl.pc_store || ctrl.jal || ctrl.jalr || ctrl.halt ||
                         ctrl == '0))
    else $error("outputs after pvs_update do not match an IF state");

endmodule

bind control_unit control_unit_assert i_assert (
  .clk   (clk),
  .rst_n (rst_n),
  .ctrl  (ctrl)
);

`default_nettype wire

/* control_unit_tb.sv */
`default_nettype none

module control_unit_tb;

  import ctrl_pkg::*;

  logic        clk;
  logic        rst_n;
  opcode_t     opcode;
  func_t       func_code;
  ctrl_sig_t   ctrl;

  int          err_count = 0;
  int          tests_run = 0;
  int          tests_failed = 0;
  int          cyc_count = 0;
  logic [31:0] lfsr;
  ctrl_state_t exp_path[$];
  logic [9:0]  enc_list[$]; // {opcode, func_code}

  control_unit i_dut (
    .clk       (clk),
    .rst_n     (rst_n),
    .opcode    (opcode),
    .func_code (func_code),
    .ctrl      (ctrl)
  );

  initial begin
    clk = 1'b0;
    forever #2 clk = ~clk;
  end

  always @(posedge clk) cyc_count <= cyc_count + 1;

  task automatic check_eq(input logic [31:0] got, input logic [31:0] exp, input string what);
    if (got !== exp) begin
      err_count++;
      $display("ERR %0t: %s, got %h expected %h", $time, what, got, exp);
    end
  endtask

  task automatic report_test(input string name, input int errors_before);
    tests_run++;
    if (err_count == errors_before) begin
      $display("test %-8s ok", name);
    end else begin
      tests_failed++;
      $display("test %-8s failed with %0d errors", name, err_count - errors_before);
    end
  endtask

  function automatic logic [31:0] lfsr_next(input logic [31:0] s);
    if (s[0]) return (s >> 1) ^ 32'ha300_0000;
    return s >> 1;
  endfunction

  task automatic draw_bits(input int n, output int unsigned val);
    val = 0;
    for (int i = 0; i < n; i++) begin
      lfsr = lfsr_next(lfsr);
      val = {val[30:0], lfsr[0]};
    end
  endtask

  function automatic inst_class_t ref_classify(input opcode_t op, input func_t fn);
    if (op == op_rtype) begin
      if (fn <= fn_shr) return cls_alu_r;
      if (fn == fn_jpr) return cls_jpr;
      if (fn == fn_jrl) return cls_jrl;
      if (fn == fn_wwd) return cls_wwd;
      if (fn == fn_hlt) return cls_hlt;
      return cls_illegal;
    end
    if (op <= op_blz) return cls_branch;
    if (op <= op_lhi) return cls_imm;
    if (op == op_lwd) return cls_lwd;
    if (op == op_swd) return cls_swd;
    if (op == op_jmp) return cls_jmp;
    if (op == op_jal) return cls_jal;
    return cls_illegal;
  endfunction

  task automatic fill_path(input inst_class_t cls);
    case (cls)
      cls_alu_r, cls_imm: exp_path = {st_if, st_ex1, st_wb};
      cls_lwd:            exp_path = {st_if, st_ex1, st_mem, st_wb};
      cls_swd:            exp_path = {st_if, st_ex1, st_mem};
      cls_branch:         exp_path = {st_if, st_ex1, st_ex2};
      cls_jpr, cls_jmp:   exp_path = {st_if, st_ex1};
      cls_jrl, cls_jal:   exp_path = {st_if, st_wb};
      cls_wwd:            exp_path = {st_if};
      default:            exp_path = {}; // never retires
    endcase
  endtask

  function automatic ctrl_sig_t ref_ctrl(input inst_class_t cls, input ctrl_state_t st,
                                         input logic last);
    ctrl_sig_t c;
    c = '0;
    case ({cls, st})
      {cls_alu_r, st_if},
      {cls_imm, st_if},
      {cls_lwd, st_if},
      {cls_swd, st_if}:    c = '{pc_store: 1'b1, default: 1'b0};
      {cls_alu_r, st_ex1}: c = '{alu_src_a: 1'b1, alu_op: 1'b1, default: 1'b0};
      {cls_alu_r, st_wb}:  c = '{reg_write: 1'b1, alu_src_a: 1'b1, alu_op: 1'b1, default: 1'b0};
      {cls_jpr, st_if},
      {cls_jpr, st_ex1}:   c = '{jalr: 1'b1, default: 1'b0};
      {cls_jrl, st_if}:    c = '{pc_store: 1'b1, jalr: 1'b1, default: 1'b0};
      {cls_jrl, st_wb}:    c = '{reg_write: 1'b1, pc_to_reg: 1'b1, jalr: 1'b1, default: 1'b0};
      {cls_imm, st_ex1},
      {cls_lwd, st_ex1},
      {cls_swd, st_ex1}:   c = '{alu_src_a: 1'b1, alu_src_b: 1'b1, alu_op: 1'b1, default: 1'b0};
      {cls_imm, st_wb}:    c = '{reg_write: 1'b1, reg_dst: 1'b1, alu_src_a: 1'b1,
                                 alu_src_b: 1'b1, alu_op: 1'b1, default: 1'b0};
      {cls_lwd, st_mem}:   c = '{mem_read: 1'b1, alu_src_a: 1'b1, alu_src_b: 1'b1,
                                 alu_op: 1'b1, default: 1'b0};
      {cls_lwd, st_wb}:    c = '{reg_write: 1'b1, reg_dst: 1'b1, mem_to_reg: 1'b1,
                                 alu_op: 1'b1, default: 1'b0};
      {cls_swd, st_mem}:   c = '{mem_write: 1'b1, alu_src_a: 1'b1, alu_src_b: 1'b1,
                                 alu_op: 1'b1, default: 1'b0};
      {cls_branch, st_if}: c = '{pc_store: 1'b1, branch: 1'b1, default: 1'b0};
      {cls_branch, st_ex1}: c = '{alu_src_a: 1'b1, alu_src_b: 1'b1, branch_dst_store: 1'b1,
                                  branch: 1'b1, default: 1'b0};
      {cls_branch, st_ex2}: c = '{alu_src_a: 1'b1, branch: 1'b1, alu_op: 1'b1, default: 1'b0};
      {cls_jmp, st_if},
      {cls_jal, st_if}:    c = '{jal: 1'b1, default: 1'b0};
      {cls_jmp, st_ex1}:   c = '{jal: 1'b1, alu_op: 1'b1, default: 1'b0};
      {cls_jal, st_wb}:    c = '{jal: 1'b1, reg_write: 1'b1, pc_to_reg: 1'b1, default: 1'b0};
      {cls_wwd, st_if}:    c = '{pc_store: 1'b1, wwd: 1'b1, default: 1'b0};
      {cls_hlt, st_if}:    c = '{halt: 1'b1, default: 1'b0};
      default:             c = '0;
    endcase
    c.pvs_update = last;
    return c;
  endfunction

  // presents one instruction at a falling edge and follows it to retirement
  task automatic run_instr(input opcode_t op, input func_t fn, input string tag,
                           output int cycles, output int exp_len);
    inst_class_t cls;
    ctrl_state_t st;
    ctrl_sig_t   exp;
    logic        done;
    cls = ref_classify(op, fn);
    fill_path(cls);
    exp_len = exp_path.size();
    cycles = 0;
    done = 1'b0;
    @(negedge clk);
    opcode = op;
    func_code = fn;
    #1;
    while (!done && cycles < 8) begin
      st = (cycles < exp_len) ? exp_path[cycles] : st_if;
      exp = ref_ctrl(cls, st, cycles == exp_len - 1);
      check_eq({15'd0, ctrl}, {15'd0, exp}, $sformatf("%s ctrl in cycle %0d", tag, cycles));
      done = ctrl.pvs_update;
      cycles++;
      if (!done && cycles < 8) begin
        @(negedge clk);
        #1;
      end
    end
    if (!done) begin
      err_count++;
      $display("%s: timed out waiting for pvs_update", tag);
    end
    check_eq(cycles, exp_len, $sformatf("%s cycle count", tag));
  endtask

  task automatic hold_check(input opcode_t op, input func_t fn, input string tag);
    ctrl_sig_t exp;
    exp = ref_ctrl(ref_classify(op, fn), st_if, 1'b0);
    @(negedge clk);
    opcode = op;
    func_code = fn;
    for (int i = 0; i < 10; i++) begin
      if (i != 0) @(negedge clk);
      #1;
      check_eq({15'd0, ctrl}, {15'd0, exp}, $sformatf("%s held cycle %0d", tag, i));
    end
  endtask

  task automatic test_reset();
    int        e0;
    int        waited;
    ctrl_sig_t exp;
    e0 = err_count;
    exp = '{pc_store: 1'b1, branch: 1'b1, default: 1'b0}; // bne in IF
    @(posedge clk);
    @(negedge clk);
    #1;
    check_eq({15'd0, ctrl}, {15'd0, exp}, "ctrl during reset");
    @(negedge clk);
    rst_n = 1'b1;
    #1;
    check_eq({15'd0, ctrl}, {15'd0, exp}, "ctrl after reset");
    waited = 0;
    while (!ctrl.pvs_update && waited < 8) begin
      @(negedge clk);
      #1;
      waited++;
    end
    if (!ctrl.pvs_update) begin
      err_count++;
      $display("reset: the bne after reset never raised pvs_update");
    end
    check_eq(waited, 2, "bne cycles after reset");
    report_test("reset", e0);
  endtask

  task automatic test_paths();
    int e0;
    int cycles;
    int exp_len;
    e0 = err_count;
    run_instr(op_rtype, fn_add, "add", cycles, exp_len);
    run_instr(op_rtype, fn_jpr, "jpr", cycles, exp_len);
    run_instr(op_rtype, fn_jrl, "jrl", cycles, exp_len);
    run_instr(op_adi, 6'd0, "adi", cycles, exp_len);
    run_instr(op_lwd, 6'd0, "lwd", cycles, exp_len);
    run_instr(op_swd, 6'd0, "swd", cycles, exp_len);
    run_instr(op_beq, 6'd0, "beq", cycles, exp_len);
    run_instr(op_jmp, 6'd0, "jmp", cycles, exp_len);
    run_instr(op_jal, 6'd0, "jal", cycles, exp_len);
    run_instr(op_rtype, fn_wwd, "wwd", cycles, exp_len);
    report_test("paths", e0);
  endtask

  task automatic test_groups();
    int e0;
    int cycles;
    int exp_len;
    e0 = err_count;
    for (int f = 0; f < 8; f++) begin
      run_instr(op_rtype, func_t'(f), $sformatf("alu fn %0d", f), cycles, exp_len);
    end
    for (int o = 0; o < 7; o++) begin // branches then immediates
      run_instr(opcode_t'(o), 6'h3f, $sformatf("opcode %0d", o), cycles, exp_len);
    end
    report_test("groups", e0);
  endtask

  task automatic test_holds();
    int e0;
    e0 = err_count;
    hold_check(op_rtype, fn_hlt, "hlt");
    hold_check(opcode_t'(11), fn_add, "illegal");
    report_test("holds", e0);
  endtask

  task automatic test_stream();
    int          e0;
    int          idx;
    int          c0;
    int          cycles;
    int          exp_len;
    int          sum_exp;
    int unsigned bits;
    logic [9:0]  enc;
    func_t       fn;
    e0 = err_count;
    sum_exp = 0;
    c0 = cyc_count;
    for (int n = 0; n < 200; n++) begin
      draw_bits(5, bits);
      idx = bits % enc_list.size();
      enc = enc_list[idx];
      fn = enc[5:0];
      if (enc[9:6] != op_rtype) begin
        draw_bits(6, bits); // func_code is don't-care here
        fn = func_t'(bits);
      end
      run_instr(enc[9:6], fn, $sformatf("stream %0d", n), cycles, exp_len);
      sum_exp += exp_len;
    end
    check_eq(cyc_count - c0, sum_exp, "stream total cycles");
    report_test("stream", e0);
  endtask

  initial begin
    rst_n = 1'b0;
    opcode = op_bne;
    func_code = fn_add;
    lfsr = 32'ha4121baf;
    for (int o = 0; o <= 10; o++) enc_list.push_back({opcode_t'(o), 6'd0});
    for (int f = 0; f < 8; f++) enc_list.push_back({op_rtype, func_t'(f)});
    enc_list.push_back({op_rtype, fn_jpr});
    enc_list.push_back({op_rtype, fn_jrl});
    enc_list.push_back({op_rtype, fn_wwd});
    test_reset();
    test_paths();
    test_groups();
    test_holds();
    test_stream();
    $display("summary: %0d tests, %0d failed, %0d errors", tests_run, tests_failed, err_count);
    if (err_count == 0 && tests_failed == 0) begin
      $display("*** PASSED ***");
    end else begin
      $display("*** FAILED ***");
    end
    $finish;
  end

endmodule

`default_nettype wire

/* control_unit.f */
ctrl_pkg.sv
inst_decoder.sv
state_sequencer.sv
ctrl_signal_gen.sv
control_unit.sv
control_unit_assert.sv
control_unit_tb.sv

/* Makefile */
VERILATOR = verilator
VFLAGS    = --binary --timing --assert -j 0
TOP       = control_unit_tb
FILELIST  = control_unit.f
OBJ_DIR   = obj_dir
PASS_MSG  = *** PASSED ***

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)
	./$(OBJ_DIR)/V$(TOP) | tee /dev/stderr | grep -qF "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)
